/* dv/fetch_cases.txt */
# c stall host | p addr count words | b addr byte_we data | e count then pc inst pairs | r runs
# counts and c fields are decimal, addresses and words are hex
# sequential run ending in a self loop, then byte enables on a spare word
c 0 0
p 1C000000 6 02800421 02800842 02800c63 00150004 0015000d 50000000
p 1C000100 1 a5a5a5a5
b 1C000100 3 12345678
b 1C000100 8 ff000000
e 8 1C000000 02800421 1C000004 02800842 1C000008 02800c63 1C00000C 00150004
    1C000010 0015000d 1C000014 50000000 1C000014 50000000 1C000014 50000000
r
# forward B, forward BL, backward BL into a three word loop
c 0 0
p 1C000000 10 02800421 50000c00 0015000d 0015000e 02800842
    54000800 0015000f 02800c63 57fffbff 0015001f
e 10 1C000000 02800421 1C000004 50000c00 1C000010 02800842 1C000014 54000800
    1C00001C 02800c63 1C000020 57fffbff 1C000018 0015000f 1C00001C 02800c63
    1C000020 57fffbff 1C000018 0015000f
r
# same program under random back-pressure
c 1 0
p 1C000000 10 02800421 50000c00 0015000d 0015000e 02800842
    54000800 0015000f 02800c63 57fffbff 0015001f
e 16 1C000000 02800421 1C000004 50000c00 1C000010 02800842 1C000014 54000800
    1C00001C 02800c63 1C000020 57fffbff 1C000018 0015000f 1C00001C 02800c63
    1C000020 57fffbff 1C000018 0015000f 1C00001C 02800c63 1C000020 57fffbff
    1C000018 0015000f 1C00001C 02800c63 1C000020 57fffbff 1C000018 0015000f
r
# same program with random host reads competing for the sram
c 0 1
p 1C000000 10 02800421 50000c00 0015000d 0015000e 02800842
    54000800 0015000f 02800c63 57fffbff 0015001f
e 16 1C000000 02800421 1C000004 50000c00 1C000010 02800842 1C000014 54000800
    1C00001C 02800c63 1C000020 57fffbff 1C000018 0015000f 1C00001C 02800c63
    1C000020 57fffbff 1C000018 0015000f 1C00001C 02800c63 1C000020 57fffbff
    1C000018 0015000f 1C00001C 02800c63 1C000020 57fffbff 1C000018 0015000f
r

/* dv/tb_fetch_top.sv */
`timescale 1ns/1ns

module tb_fetch_top;

    localparam string       CASE_FILE      = "dv/fetch_cases.txt";
    localparam logic [31:0] LFSR_SEED      = 32'h7dec;
    // timeout budget per case
    localparam int          CYCLES_PER_OUT = 8;
    localparam int          TIMEOUT_SLACK  = 200;

    logic                          clk;
    logic                          resetn;
    logic                          fetch_run;
    logic                          host_en;
    logic [3:0]                    host_we;
    logic [31:0]                   host_addr;
    logic [31:0]                   host_wdata;
    logic [31:0]                   host_rdata;
    logic                          host_rvalid;
    logic                          es_allowin;
    logic                          ds2es_valid;
    logic [cpu_pkg::DS2ES_LEN-1:0] ds2es_bus;

    // words as written by the host
    logic [31:0] model [mem_pkg::MEM_WORDS];
    logic [31:0] prog_addr [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_inst [$];
    logic [31:0] lfsr;
    // result of a host read due at the next sample
    logic        rd_pend;
    logic [31:0] rd_exp;
    // output word stalled by es_allowin
    logic        hold_pend;
    logic [63:0] hold_bus;
    logic        running;
    logic        first_check;
    int          n_out;
    int          cycles;
    int          limit;

    fetch_top dut (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_run   (fetch_run),
        .host_en     (host_en),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .es_allowin  (es_allowin),
        .ds2es_valid (ds2es_valid),
        .ds2es_bus   (ds2es_bus)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic int word_index(logic [31:0] a);
        return int'((a - mem_pkg::MEM_BASE) >> 2);
    endfunction

    // only lanes with we set take new data
    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [3:0] we,
                                                logic [31:0] data);
        logic [31:0] r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                r[8*i +: 8] = data[8*i +: 8];
            end
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // sampled at the falling edge with outputs settled
    task automatic sample();
        check("host_rvalid", 64'(host_rvalid), 64'(rd_pend));
        if (rd_pend) begin
            check("host_rdata", 64'(host_rdata), 64'(rd_exp));
        end
        rd_pend = host_en && host_we == 4'b0000;
        if (rd_pend) begin
            rd_exp = model[word_index(host_addr)];
        end
        if (hold_pend) begin
            check("ds2es_valid", 64'(ds2es_valid), 64'd1);
            check("ds2es_bus", ds2es_bus, hold_bus);
        end
        hold_pend = ds2es_valid && !es_allowin;
        hold_bus  = ds2es_bus;
        // word moves at the coming edge
        if (running && ds2es_valid && es_allowin && n_out < exp_pc.size()) begin
            if (n_out == 0 && first_check) begin
                check("first ds2es_valid cycle", 64'(cycles), 64'd2);
            end
            check("ds2es_bus[31:0] pc", 64'(ds2es_bus[31:0]), 64'(exp_pc[n_out]));
            check("ds2es_bus[63:32] inst", 64'(ds2es_bus[63:32]), 64'(exp_inst[n_out]));
            n_out++;
        end
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("timeout: %0d of %0d outputs seen after %0d cycles",
                                    n_out, exp_pc.size(), cycles));
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        sample();
        @(posedge clk);
        #5;
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [3:0] we,
                              input logic [31:0] data);
        host_en    = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = data;
        model[word_index(addr)] = merge_bytes(model[word_index(addr)], we, data);
        tick();
        host_en = 1'b0;
        host_we = 4'b0000;
    endtask

    task automatic host_read(input logic [31:0] addr);
        host_en   = 1'b1;
        host_we   = 4'b0000;
        host_addr = addr;
        tick();
        host_en = 1'b0;
    endtask

    // 8 cycles of reset and an idle state check
    task automatic reset_dut();
        resetn     = 1'b0;
        fetch_run  = 1'b0;
        host_en    = 1'b0;
        host_we    = 4'b0000;
        es_allowin = 1'b1;
        rd_pend    = 1'b0;
        hold_pend  = 1'b0;
        running    = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        resetn = 1'b1;
        @(negedge clk);
        check("ds2es_valid", 64'(ds2es_valid), 64'd0);
        check("host_rvalid", 64'(host_rvalid), 64'd0);
        @(posedge clk);
        #5;
    endtask

    task automatic run_fetch(input logic stall, input logic host_rd);
        logic [7:0] r;
        int         idx;
        n_out       = 0;
        cycles      = 0;
        limit       = exp_pc.size() * CYCLES_PER_OUT + TIMEOUT_SLACK;
        first_check = !stall && !host_rd;
        running     = 1'b1;
        fetch_run   = 1'b1;
        while (n_out < exp_pc.size()) begin
            es_allowin = 1'b1;
            host_en    = 1'b0;
            if (stall) begin
                rand_bits(1, r);
                es_allowin = r[0];
            end
            if (host_rd) begin
                rand_bits(1, r);
                if (r[0]) begin
                    rand_bits(4, r);
                    idx       = int'(r) % prog_addr.size();
                    host_en   = 1'b1;
                    host_we   = 4'b0000;
                    host_addr = prog_addr[idx];
                end
            end
            tick();
        end
        running    = 1'b0;
        fetch_run  = 1'b0;
        host_en    = 1'b0;
        es_allowin = 1'b1;
        // last host result still due
        tick();
    endtask

    // rest of a comment line
    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != -1 && c != 10) begin
            c = $fgetc(fd);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          n;
        int          cnt;
        int          stall_i;
        int          host_i;
        int          n_cases;
        logic [7:0]  tag;
        logic [31:0] addr;
        logic [31:0] word;
        logic [3:0]  we;
        resetn     = 1'b0;
        fetch_run  = 1'b0;
        host_en    = 1'b0;
        host_we    = 4'b0000;
        host_addr  = 32'h0;
        host_wdata = 32'h0;
        es_allowin = 1'b1;
        lfsr       = LFSR_SEED;
        n_cases    = 0;
        stall_i    = 0;
        host_i     = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the case file dv/fetch_cases.txt");
        end
        code = $fgetc(fd);
        while (code != -1) begin
            tag = code[7:0];
            case (tag)
                " ", "\t", "\n", "\r": begin
                end
                "#": skip_line(fd);
                // new case starts from reset
                "c": begin
                    n = $fscanf(fd, "%d %d", stall_i, host_i);
                    if (n != 2) begin
                        abort_run("case header in the case file is malformed");
                    end
                    prog_addr.delete();
                    exp_pc.delete();
                    exp_inst.delete();
                    reset_dut();
                end
                "p": begin
                    n = $fscanf(fd, "%h %d", addr, cnt);
                    for (int k = 0; k < cnt; k++) begin
                        n = $fscanf(fd, "%h", word);
                        host_write(addr, 4'hf, word);
                        prog_addr.push_back(addr);
                        addr = addr + 32'd4;
                    end
                end
                // partial write read straight back
                "b": begin
                    n = $fscanf(fd, "%h %h %h", addr, we, word);
                    host_write(addr, we, word);
                    host_read(addr);
                    tick();
                end
                "e": begin
                    n = $fscanf(fd, "%d", cnt);
                    for (int k = 0; k < cnt; k++) begin
                        n = $fscanf(fd, "%h %h", addr, word);
                        exp_pc.push_back(addr);
                        exp_inst.push_back(word);
                    end
                end
                // program readback before fetch
                "r": begin
                    foreach (prog_addr[k]) begin
                        host_read(prog_addr[k]);
                    end
                    tick();
                    run_fetch(stall_i != 0, host_i != 0);
                    n_cases++;
                end
                default: abort_run("unexpected character in the case file");
            endcase
            code = $fgetc(fd);
        end
        $fclose(fd);
        if (n_cases == 0) begin
            abort_run("the case file holds no cases");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // first instruction fetched after reset
    localparam logic [31:0] RESET_PC = 32'h1C00_0000;

    // pc register value held in reset
    // the first sequential step lands on RESET_PC
    localparam logic [31:0] PC_INIT = RESET_PC - 32'd4;

    // branch bundle from decode to fetch
    // {taken, target}
    localparam int BR_BUS_LEN = 33;

    // fetch to decode bus
    // {inst, pc}
    localparam int FS2DS_LEN = 64;

    // decode output bus
    // {inst, pc}, passed on undecoded
    localparam int DS2ES_LEN = 64;

    // major opcodes, inst[31:26]
    localparam logic [5:0] OP_B  = 6'b010100;
    localparam logic [5:0] OP_BL = 6'b010101;

endpackage

/* hdl/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          fetch_run,
    // host port
    input  logic                          host_en,
    input  logic [3:0]                    host_we,
    input  logic [31:0]                   host_addr,
    input  logic [31:0]                   host_wdata,
    output logic [31:0]                   host_rdata,
    output logic                          host_rvalid,
    // decode output
    input  logic                          es_allowin,
    output logic                          ds2es_valid,
    output logic [cpu_pkg::DS2ES_LEN-1:0] ds2es_bus
);

    // fetch port
    logic                           inst_sram_en;
    logic [31:0]                    inst_sram_addr;
    logic                           inst_sram_gnt;
    logic [31:0]                    inst_sram_rdata;
    // fetch to decode
    logic                           fs2ds_valid;
    logic [cpu_pkg::FS2DS_LEN-1:0]  fs2ds_bus;
    logic                           ds_allowin;
    logic [cpu_pkg::BR_BUS_LEN-1:0] br_zip;
    // sram side of the arbiter
    logic                           mem_en;
    logic [3:0]                     mem_we;
    logic [mem_pkg::WADDR_W-1:0]    mem_addr;
    logic [31:0]                    mem_wdata;
    logic [31:0]                    mem_rdata;

    if_stage u_if_stage (
        .clk             (clk),
        .resetn          (resetn),
        .fetch_run       (fetch_run),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_gnt   (inst_sram_gnt),
        .inst_sram_rdata (inst_sram_rdata),
        .ds_allowin      (ds_allowin),
        .br_zip          (br_zip),
        .fs2ds_valid     (fs2ds_valid),
        .fs2ds_bus       (fs2ds_bus)
    );

    id_stage u_id_stage (
        .clk         (clk),
        .resetn      (resetn),
        .fs2ds_valid (fs2ds_valid),
        .fs2ds_bus   (fs2ds_bus),
        .ds_allowin  (ds_allowin),
        .br_zip      (br_zip),
        .es_allowin  (es_allowin),
        .ds2es_valid (ds2es_valid),
        .ds2es_bus   (ds2es_bus)
    );

    sram_arbiter u_sram_arbiter (
        .clk             (clk),
        .resetn          (resetn),
        .host_en         (host_en),
        .host_we         (host_we),
        .host_addr       (host_addr),
        .host_wdata      (host_wdata),
        .host_rdata      (host_rdata),
        .host_rvalid     (host_rvalid),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_gnt   (inst_sram_gnt),
        .inst_sram_rdata (inst_sram_rdata),
        .mem_en          (mem_en),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata)
    );

    inst_sram u_inst_sram (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
    input  logic                           clk,
    input  logic                           resetn,
    // from fetch
    input  logic                           fs2ds_valid,
    input  logic [cpu_pkg::FS2DS_LEN-1:0]  fs2ds_bus,
    output logic                           ds_allowin,
    // redirect to fetch
    output logic [cpu_pkg::BR_BUS_LEN-1:0] br_zip,
    // to next stage
    input  logic                           es_allowin,
    output logic                           ds2es_valid,
    output logic [cpu_pkg::DS2ES_LEN-1:0]  ds2es_bus
);

    logic                          ds_valid;
    logic [cpu_pkg::DS2ES_LEN-1:0] ds_bus;
    logic                          ds_accept;
    logic                          drop;
    logic                          cancel_q;
    logic [31:0]                   in_inst;
    logic [31:0]                   in_pc;
    logic [25:0]                   offs;
    logic [31:0]                   in_target;
    logic                          in_is_br;
    logic                          br_taken;
    logic [31:0]                   br_target;

    assign {in_inst, in_pc} = fs2ds_bus;

    // only B and BL are recognized and both are always taken
    assign in_is_br = (in_inst[31:26] == cpu_pkg::OP_B) ||
                      (in_inst[31:26] == cpu_pkg::OP_BL);

    // offs[15:0] in inst[25:10], offs[25:16] in inst[9:0]
    assign offs      = {in_inst[9:0], in_inst[25:10]};
    assign in_target = in_pc + {{4{offs[25]}}, offs, 2'b00};

    // single cycle stage
    assign ds_allowin = ~ds_valid | es_allowin;
    assign ds_accept  = fs2ds_valid & ds_allowin;

    // wrong path word
    // either the one arriving while the redirect is out, or one flagged earlier
    assign drop = cancel_q | br_taken;

    // flag stays set until the wrong-path word is taken in
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_q <= 1'b0;
        end else if (ds_accept && drop) begin
            cancel_q <= 1'b0;
        end else if (br_taken && fs2ds_valid) begin
            cancel_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs2ds_valid & ~drop;
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (ds_accept && !drop) begin
            ds_bus <= fs2ds_bus;
        end
    end

    // redirect pulse in the cycle after the branch is taken in
    always_ff @(posedge clk) begin
        if (!resetn) begin
            br_taken <= 1'b0;
        end else begin
            br_taken <= ds_accept & ~drop & in_is_br;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_accept) begin
            br_target <= in_target;
        end
    end

    assign br_zip      = {br_taken, br_target};
    assign ds2es_valid = ds_valid;
    assign ds2es_bus   = ds_bus;

    // a dropped word is always the one right behind the branch held here
    a_drop_next_word: assert property (@(posedge clk) disable iff (!resetn)
        ds_accept && drop |-> in_pc == ds_bus[31:0] + 32'd4);

endmodule

/* hdl/if_stage.sv */
`timescale 1ns/1ns

module if_stage (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           fetch_run,
    // sram fetch port
    output logic                           inst_sram_en,
    output logic [31:0]                    inst_sram_addr,
    input  logic                           inst_sram_gnt,
    input  logic [31:0]                    inst_sram_rdata,
    // from decode
    input  logic                           ds_allowin,
    input  logic [cpu_pkg::BR_BUS_LEN-1:0] br_zip,
    // to decode
    output logic                           fs2ds_valid,
    output logic [cpu_pkg::FS2DS_LEN-1:0]  fs2ds_bus
);

    logic        fs_valid;
    logic        fs_allowin;
    logic        fs_accept;
    logic [31:0] fs_pc;
    logic [31:0] fs_inst;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;
    logic        br_taken;
    logic [31:0] br_target;
    logic        br_pend;
    logic [31:0] br_pend_target;
    logic        rdata_fresh;
    logic [31:0] inst_buf;

    assign {br_taken, br_target} = br_zip;

    // next pc select
    // live redirect first, then a redirect still waiting for a grant
    assign seq_pc = fs_pc + 32'd4;
    always_comb begin
        if (br_taken) begin
            nextpc = br_target;
        end else if (br_pend) begin
            nextpc = br_pend_target;
        end else begin
            nextpc = seq_pc;
        end
    end

    // stage can take a new word when empty or when decode takes ours
    assign fs_allowin  = ~fs_valid | ds_allowin;
    assign fs2ds_valid = fs_valid;

    // fetch request, idle while the host loads
    assign inst_sram_en   = fetch_run & fs_allowin;
    assign inst_sram_addr = nextpc;
    assign fs_accept      = inst_sram_en & inst_sram_gnt;

    // valid follows the grant, drops when the word leaves without refill
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= fs_accept;
        end
    end

    // pc of the word now in fetch
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_pc <= cpu_pkg::PC_INIT;
        end else if (fs_accept) begin
            fs_pc <= nextpc;
        end
    end

    // br_taken lasts one cycle
    // keep the target if the fetch could not go out that cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            br_pend <= 1'b0;
        end else if (fs_accept) begin
            br_pend <= 1'b0;
        end else if (br_taken) begin
            br_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken) begin
            br_pend_target <= br_target;
        end
    end

    // sram data is ours only in the cycle after the grant
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata_fresh <= 1'b0;
        end else begin
            rdata_fresh <= fs_accept;
        end
    end

    // hold buffer, host reads may overwrite the sram output later
    always_ff @(posedge clk) begin
        if (rdata_fresh) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_inst   = rdata_fresh ? inst_sram_rdata : inst_buf;
    assign fs2ds_bus = {fs_inst, fs_pc};

    // stalled word keeps pc and inst, even across host traffic
    a_hold_stalled: assert property (@(posedge clk) disable iff (!resetn)
        fs2ds_valid && !ds_allowin |=> $stable(fs2ds_bus));

endmodule

/* hdl/inst_sram.sv */
`timescale 1ns/1ns

module inst_sram (
    input  logic                        clk,
    input  logic                        en,
    input  logic [3:0]                  we,
    input  logic [mem_pkg::WADDR_W-1:0] addr,
    input  logic [31:0]                 wdata,
    output logic [31:0]                 rdata
);

    // word array, contents undefined until loaded by the host
    logic [31:0] mem [mem_pkg::MEM_WORDS];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, one cycle latency
    // old data on a write cycle (read first)
    // output keeps last value while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* hdl/mem_pkg.sv */
package mem_pkg;

    // sram depth in 32-bit words
    localparam int MEM_WORDS = 256;

    // word index width, log2 of MEM_WORDS
    localparam int WADDR_W = 8;

    // byte address of word 0
    // same as the reset pc so the program starts at index 0
    localparam logic [31:0] MEM_BASE = 32'h1C00_0000;

endpackage

/* hdl/sram_arbiter.sv */
`timescale 1ns/1ns

module sram_arbiter (
    input  logic                        clk,
    input  logic                        resetn,
    // host port
    input  logic                        host_en,
    input  logic [3:0]                  host_we,
    input  logic [31:0]                 host_addr,
    input  logic [31:0]                 host_wdata,
    output logic [31:0]                 host_rdata,
    output logic                        host_rvalid,
    // fetch port
    input  logic                        inst_sram_en,
    input  logic [31:0]                 inst_sram_addr,
    output logic                        inst_sram_gnt,
    output logic [31:0]                 inst_sram_rdata,
    // memory port
    output logic                        mem_en,
    output logic [3:0]                  mem_we,
    output logic [mem_pkg::WADDR_W-1:0] mem_addr,
    output logic [31:0]                 mem_wdata,
    input  logic [31:0]                 mem_rdata
);

    logic [31:0] sel_addr;
    logic [31:0] off_addr;
    logic        host_rd_q;

    // host wins whenever it strobes
    assign inst_sram_gnt = ~host_en;

    assign sel_addr = host_en ? host_addr : inst_sram_addr;
    // byte address relative to sram base
    assign off_addr = sel_addr - mem_pkg::MEM_BASE;

    assign mem_en    = host_en | inst_sram_en;
    // fetch never writes
    assign mem_we    = host_en ? host_we : 4'b0000;
    assign mem_addr  = off_addr[mem_pkg::WADDR_W+1:2];
    assign mem_wdata = host_wdata;

    // owner of the read in flight
    // set for one cycle after an accepted host read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            host_rd_q <= 1'b0;
        end else begin
            host_rd_q <= host_en & (host_we == 4'b0000);
        end
    end

    // both sides see the same sram output
    // each side knows from its own valid when it is meant for it
    assign host_rdata      = mem_rdata;
    assign host_rvalid     = host_rd_q;
    assign inst_sram_rdata = mem_rdata;

    // every access must fall inside the array
    a_addr_in_range: assert property (@(posedge clk) disable iff (!resetn)
        mem_en |-> off_addr < 32'(mem_pkg::MEM_WORDS * 4));

endmodule

/* project.f */
hdl/cpu_pkg.sv
hdl/mem_pkg.sv
hdl/inst_sram.sv
hdl/sram_arbiter.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/fetch_top.sv
dv/tb_fetch_top.sv

/* run.sh */
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fetch_top -f project.f \
    -o sim_fetch_top || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_fetch_top)
echo "$out"
echo "$out" | grep -q "^Verification passed$" && echo "PASS" || { echo "FAIL"; exit 1; }
